//--- Makefile
# Verilator build and run of the multiply unit testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f flist.f --top-module tbMulUnit -Mdir obj_dir -o simMul

run: compile
	./obj_dir/simMul | tee sim.log
	@if grep -q "=== FAIL ===" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" sim.log || (echo "Simulation incomplete"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- flist.f
src/mulPkg.sv
src/operandSplit.sv
src/partialMul.sv
src/productCombine.sv
src/mulCtrl.sv
src/mulUnit.sv
verif/mulChecker.sv
verif/tbMulUnit.sv

//--- src/mulCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module mulCtrl (
    input  wire logic          clk,
    input  wire logic          rstN,
    input  wire logic          mulReq,
    input  wire logic          cancel,
    input  wire logic          isAccum,      // madd/msub style op
    input  wire logic          addNotSub,    // 1 add, 0 subtract
    input  wire mulPkg::dwordT hiLo,         // Held by the core until done
    input  wire mulPkg::dwordT product,
    output logic               load,         // Accept strobe
    output logic               opReady,
    output logic               resultValid,  // One-cycle done pulse
    output mulPkg::dwordT      mulRes
);
    import mulPkg::*;

    ctrlStateT   state;
    logic [1:0]  timer;      // Cycles since accept
    logic        accR;       // Latched isAccum
    logic        addR;       // Latched addNotSub
    logic        carryR;     // Carry out of the low add
    wordT        sumLoR;     // Saved low sum
    logic        lowStep;    // Cycle 2 of an accumulate
    wordT        loAddend;
    wordT        hiAddend;
    logic [32:0] loSum;
    wordT        hiSum;

    // --------------------------------------------------------------------------
    // Handshake
    // --------------------------------------------------------------------------
    assign resultValid = (state == MULT && timer == 2'd2 && !accR) || state == ACCLO;
    assign opReady     = mulReq && !cancel && (state == IDLE || resultValid);  // Overlap on done
    assign load        = mulReq && opReady;
    assign lowStep     = state == MULT && timer == 2'd2 && accR;

    // --------------------------------------------------------------------------
    // Split 64-bit accumulate
    // --------------------------------------------------------------------------
    // Subtract as hiLo + ~product + 1, the +1 enters at the low half
    assign loAddend = addR ? product[31:0] : ~product[31:0];
    assign hiAddend = addR ? product[63:32] : ~product[63:32];
    assign loSum    = {1'b0, hiLo[31:0]} + {1'b0, loAddend} + {32'd0, !addR};
    assign hiSum    = hiLo[63:32] + hiAddend + {31'd0, carryR};   // Carry from cycle 2

    assign mulRes = accR ? {hiSum, sumLoR} : product;

    // FSM and timer
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
            timer <= 2'd0;
            accR  <= 1'b0;
            addR  <= 1'b0;
        end else if (cancel) begin      // Drop whatever is in flight
            state <= IDLE;
            timer <= 2'd0;
            accR  <= 1'b0;
            addR  <= 1'b0;
        end else if (load) begin
            state <= MULT;
            timer <= 2'd1;              // Accept cycle counts as 0
            accR  <= isAccum;
            addR  <= addNotSub;
        end else if (resultValid) begin
            state <= IDLE;
            timer <= 2'd0;
        end else if (lowStep) begin
            state <= ACCLO;
        end else if (state == MULT) begin
            timer <= timer + 2'd1;
        end
    end

    // Low-half sum and carry
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sumLoR <= '0;
            carryR <= 1'b0;
        end else if (cancel) begin
            sumLoR <= '0;
            carryR <= 1'b0;
        end else if (lowStep) begin
            sumLoR <= loSum[31:0];
            carryR <= loSum[32];
        end
    end

    // --------------------------------------------------------------------------
    // Checks
    // --------------------------------------------------------------------------
    // Done only after a busy cycle, and only for one cycle
    aDoneNotIdle: assert property (@(posedge clk) disable iff (!rstN)
        resultValid |-> $past(state) != IDLE ##1 !resultValid);

    // Accept starts the timer
    aLoadReady: assert property (@(posedge clk) disable iff (!rstN)
        load |=> state == MULT && timer == 2'd1);

endmodule

`default_nettype wire

//--- src/mulPkg.sv
`default_nettype none

package mulPkg;

    // --------------------------------------------------------------------------
    // Data widths of the multiply unit
    // --------------------------------------------------------------------------
    typedef logic [31:0] wordT;     // Operand or result half
    typedef logic [15:0] halfT;     // Slice input
    typedef logic [63:0] dwordT;    // Product, HI/LO, result
    typedef logic [31:0] partT;     // One 16x16 slice product

    // --------------------------------------------------------------------------
    // Control FSM
    // --------------------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE  = 2'd0,   // Nothing in flight
        MULT  = 2'd1,   // Product in flight
        ACCLO = 2'd2    // Low half summed, high half next
    } ctrlStateT;

endpackage

`default_nettype wire

//--- src/mulUnit.sv
`timescale 1ns/1ps
`default_nettype none

module mulUnit (
    input  wire logic          clk,
    input  wire logic          rstN,
    input  wire logic          mulReq,
    input  wire logic          cancel,
    input  wire logic          isSigned,
    input  wire logic          isAccum,
    input  wire logic          addNotSub,
    input  wire mulPkg::wordT  opA,
    input  wire mulPkg::wordT  opB,
    input  wire mulPkg::dwordT hiLo,
    output logic               opReady,
    output logic               resultValid,
    output mulPkg::dwordT      mulRes
);
    import mulPkg::*;

    logic  load;
    logic  negProduct;
    halfT  aHalf0;
    halfT  aHalf1;
    halfT  bHalf0;
    halfT  bHalf1;
    halfT  sliceX [4];      // Slice pairings
    halfT  sliceY [4];
    partT  partial [4];
    dwordT product;

    // --------------------------------------------------------------------------
    // Operand stage
    // --------------------------------------------------------------------------
    operandSplit uSplit (
        .clk        (clk),
        .rstN       (rstN),
        .load       (load),
        .cancel     (cancel),
        .isSigned   (isSigned),
        .opA        (opA),
        .opB        (opB),
        .aHalf0     (aHalf0),
        .aHalf1     (aHalf1),
        .bHalf0     (bHalf0),
        .bHalf1     (bHalf1),
        .negProduct (negProduct)
    );

    // lo*lo, lo*hi, hi*lo, hi*hi
    assign sliceX = '{aHalf0, aHalf0, aHalf1, aHalf1};
    assign sliceY = '{bHalf0, bHalf1, bHalf0, bHalf1};

    // Four parallel slices
    for (genvar k = 0; k < 4; k++) begin : gSlice
        partialMul uSlice (
            .clk     (clk),
            .rstN    (rstN),
            .x       (sliceX[k]),
            .y       (sliceY[k]),
            .partial (partial[k])
        );
    end

    productCombine uCombine (
        .clk        (clk),
        .rstN       (rstN),
        .cancel     (cancel),
        .partial0   (partial[0]),
        .partial1   (partial[1]),
        .partial2   (partial[2]),
        .partial3   (partial[3]),
        .negProduct (negProduct),
        .product    (product)
    );

    // --------------------------------------------------------------------------
    // Control and accumulate
    // --------------------------------------------------------------------------
    mulCtrl uCtrl (
        .clk         (clk),
        .rstN        (rstN),
        .mulReq      (mulReq),
        .cancel      (cancel),
        .isAccum     (isAccum),
        .addNotSub   (addNotSub),
        .hiLo        (hiLo),
        .product     (product),
        .load        (load),
        .opReady     (opReady),
        .resultValid (resultValid),
        .mulRes      (mulRes)
    );

endmodule

`default_nettype wire

//--- src/operandSplit.sv
`timescale 1ns/1ps
`default_nettype none

module operandSplit (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire logic        load,        // Accept strobe
    input  wire logic        cancel,
    input  wire logic        isSigned,
    input  wire mulPkg::wordT opA,
    input  wire mulPkg::wordT opB,
    output mulPkg::halfT     aHalf0,      // Low half of |opA|
    output mulPkg::halfT     aHalf1,
    output mulPkg::halfT     bHalf0,
    output mulPkg::halfT     bHalf1,
    output logic             negProduct   // Product must be negated
);
    import mulPkg::*;

    wordT magA;
    wordT magB;
    logic negA;
    logic negB;

    // Sign bits count only for signed ops
    assign negA = isSigned && opA[31];
    assign negB = isSigned && opB[31];

    // Two's-complement magnitude
    assign magA = negA ? (~opA + 32'd1) : opA;
    assign magB = negB ? (~opB + 32'd1) : opB;  // 0x80000000 stays as is, fine unsigned

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            aHalf0     <= '0;
            aHalf1     <= '0;
            bHalf0     <= '0;
            bHalf1     <= '0;
            negProduct <= 1'b0;
        end else if (cancel) begin      // Flush wins over a same-cycle load
            aHalf0     <= '0;
            aHalf1     <= '0;
            bHalf0     <= '0;
            bHalf1     <= '0;
            negProduct <= 1'b0;
        end else if (load) begin
            aHalf0     <= magA[15:0];
            aHalf1     <= magA[31:16];
            bHalf0     <= magB[15:0];
            bHalf1     <= magB[31:16];
            negProduct <= negA ^ negB;  // Result sign
        end
    end

endmodule

`default_nettype wire

//--- src/partialMul.sv
`timescale 1ns/1ps
`default_nettype none

module partialMul (
    input  wire logic         clk,
    input  wire logic         rstN,
    input  wire mulPkg::halfT x,
    input  wire mulPkg::halfT y,
    output mulPkg::partT      partial   // x*y, one cycle later
);
    import mulPkg::*;

    partT prod;

    // Unsigned 16x16, full 32-bit result
    assign prod = partT'(x) * partT'(y);

    // --------------------------------------------------------------------------
    // Slice output register
    // --------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            partial <= '0;
        end else begin
            partial <= prod;    // Free running, inputs hold between loads
        end
    end

endmodule

`default_nettype wire

//--- src/productCombine.sv
`timescale 1ns/1ps
`default_nettype none

module productCombine (
    input  wire logic         clk,
    input  wire logic         rstN,
    input  wire logic         cancel,
    input  wire mulPkg::partT partial0,    // lo*lo
    input  wire mulPkg::partT partial1,    // lo*hi
    input  wire mulPkg::partT partial2,    // hi*lo
    input  wire mulPkg::partT partial3,    // hi*hi
    input  wire logic         negProduct,  // From the splitter, one cycle early
    output mulPkg::dwordT     product
);
    import mulPkg::*;

    logic  negD;    // Sign lined up with the slice outputs
    dwordT term0;
    dwordT term1;
    dwordT term2;
    dwordT term3;
    dwordT magnitude;

    // --------------------------------------------------------------------------
    // Sign delay, one stage to match the slice registers
    // --------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            negD <= 1'b0;
        end else if (cancel) begin
            negD <= 1'b0;
        end else begin
            negD <= negProduct;
        end
    end

    // --------------------------------------------------------------------------
    // Alignment and sum
    // --------------------------------------------------------------------------
    assign term0 = {32'd0, partial0};               // Weight 2^0
    assign term1 = {16'd0, partial1, 16'd0};        // Weight 2^16
    assign term2 = {16'd0, partial2, 16'd0};        // Weight 2^16
    assign term3 = {partial3, 32'd0};               // Weight 2^32

    // Cannot overflow, |a|*|b| < 2^64
    assign magnitude = term0 + term1 + term2 + term3;

    // Product taken straight off the slice registers, so it is ready in cycle 2
    assign product = negD ? (~magnitude + 64'd1) : magnitude;

endmodule

`default_nettype wire

//--- verif/mulChecker.sv
`timescale 1ns/1ps
`default_nettype none

module mulChecker (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire logic        mulReq,
    input  wire logic        cancel,
    input  wire logic        isSigned,
    input  wire logic        isAccum,
    input  wire logic        addNotSub,
    input  wire logic [31:0] opA,
    input  wire logic [31:0] opB,
    input  wire logic [63:0] hiLo,
    input  wire logic        opReady,
    input  wire logic        resultValid,
    input  wire logic [63:0] mulRes,
    output int               passCount,
    output int               failCount,
    output int               cancelCount,
    output int               errCount
);
    int          cycle = 0;
    int          testNo = 0;     // Accepts so far
    int          nPass = 0;
    int          nFail = 0;
    int          nCancel = 0;
    int          nErr = 0;
    logic        pendValid = 1'b0;
    int          pendNo;
    int          pendDue;        // Cycle of the expected done pulse
    logic [63:0] pendExp;
    logic        expRdy;         // Ready as the handshake rules give it

    assign passCount   = nPass;
    assign failCount   = nFail;
    assign cancelCount = nCancel;
    assign errCount    = nErr;

    // Product is exact in 64 bits once the operands are extended
    function automatic logic [63:0] expectedResult(input logic sgn, acc, add,
                                                   input logic [31:0] a, b,
                                                   input logic [63:0] h);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] p;
        ea = sgn ? {{32{a[31]}}, a} : {32'd0, a};
        eb = sgn ? {{32{b[31]}}, b} : {32'd0, b};
        p  = ea * eb;                            // Low 64 bits, modulo 2^64
        if (!acc) begin
            return p;
        end
        return add ? h + p : h - p;
    endfunction

    // ------------------------------------------------------------------------
    // Per-cycle monitor, pre-edge values
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (!rstN) begin
            if (opReady || resultValid) begin
                $display("Error at %0t: opReady or resultValid high in reset", $time);
                nErr++;
            end
            pendValid = 1'b0;
        end else begin
            // Free when idle or in the done cycle, never under cancel
            expRdy = mulReq && !cancel && (!pendValid || cycle == pendDue);
            if (opReady !== expRdy) begin
                $display("[FAIL] %0t opReady expected %b actual %b", $time, expRdy, opReady);
                nErr++;
            end
            if (resultValid) begin
                if (pendValid && cycle == pendDue) begin
                    if (mulRes === pendExp) begin
                        $display("test %0d: ok, mulRes %h", pendNo, mulRes);
                        nPass++;
                    end else begin
                        $display("[FAIL] %0t mulRes (test %0d) expected %h actual %h",
                                 $time, pendNo, pendExp, mulRes);
                        nFail++;
                    end
                    pendValid = 1'b0;
                end else begin
                    $display("Error at %0t: resultValid with no result due", $time);
                    nErr++;
                end
            end
            if (pendValid && cycle >= pendDue) begin    // Due cycle passed silently
                $display("Error at %0t: test %0d gave no resultValid on time", $time, pendNo);
                nErr++;
                pendValid = 1'b0;
            end
            if (cancel && pendValid) begin
                $display("test %0d: cancelled", pendNo);
                nCancel++;
                pendValid = 1'b0;
            end
            if (mulReq && opReady) begin                // Accept, capture operands
                testNo++;
                pendNo    = testNo;
                pendDue   = cycle + (isAccum ? 3 : 2);
                pendExp   = expectedResult(isSigned, isAccum, addNotSub, opA, opB, hiLo);
                pendValid = 1'b1;
            end
        end
        cycle++;
    end

endmodule

`default_nettype wire

//--- verif/tbMulUnit.sv
`timescale 1ns/1ps
`default_nettype none

module tbMulUnit;
    localparam int NUM_ENTRIES = 40;
    localparam int LIMIT       = 6 * NUM_ENTRIES + 50;   // Cycle budget

    logic        clk;
    logic        rstN;
    logic        mulReq;
    logic        cancel;
    logic        isSigned;
    logic        isAccum;
    logic        addNotSub;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [63:0] hiLo;
    logic        opReady;
    logic        resultValid;
    logic [63:0] mulRes;
    int          passCount;
    int          failCount;
    int          cancelCount;
    int          errCount;

    // ------------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------------
    logic [2:0]  tMode [NUM_ENTRIES];     // isSigned, isAccum, addNotSub
    logic [31:0] tA [NUM_ENTRIES];
    logic [31:0] tB [NUM_ENTRIES];
    logic [63:0] tHiLo [NUM_ENTRIES];
    logic        tCancel [NUM_ENTRIES];
    logic        tBack [NUM_ENTRIES];     // Issue in previous done cycle
    int          nEntries = 0;
    int          nCancels = 0;
    int          cycles = 0;
    logic [31:0] lfsr;

    mulUnit DUT (.*);
    mulChecker chk (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);   // Galois, right shift
    endfunction

    task automatic randBits(input int n, output logic [63:0] v);
        v = '0;
        repeat (n) begin
            lfsr = lfsrStep(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    task automatic addEntry(input logic [2:0] mode, input logic [31:0] a, b,
                            input logic [63:0] h, input logic canc, back);
        tMode[nEntries]   = mode;
        tA[nEntries]      = a;
        tB[nEntries]      = b;
        tHiLo[nEntries]   = h;
        tCancel[nEntries] = canc;
        tBack[nEntries]   = back;
        nEntries++;
        if (canc) begin
            nCancels++;
        end
    endtask

    task automatic buildTable();
        logic [63:0] mode;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] h;
        logic [63:0] c;
        logic [63:0] bk;
        logic        back;
        // Unsigned corners
        addEntry(3'b000, 32'hffffffff, 32'hffffffff, 64'd0, 1'b0, 1'b0);
        addEntry(3'b000, 32'h00000000, 32'h12345678, 64'd0, 1'b0, 1'b0);
        addEntry(3'b000, 32'h12345678, 32'h9abcdef0, 64'd0, 1'b0, 1'b0);
        // Signed, all sign pairs and the most negative value
        addEntry(3'b100, 32'hfffffffd, 32'h00000007, 64'd0, 1'b0, 1'b0);
        addEntry(3'b100, 32'h00000007, 32'hfffffffd, 64'd0, 1'b0, 1'b0);
        addEntry(3'b100, 32'hfffffffb, 32'hfffffff7, 64'd0, 1'b0, 1'b0);
        addEntry(3'b100, 32'h00007fff, 32'h7ffffffd, 64'd0, 1'b0, 1'b0);
        addEntry(3'b100, 32'h80000000, 32'hffffffff, 64'd0, 1'b0, 1'b0);
        addEntry(3'b100, 32'h80000000, 32'h80000000, 64'd0, 1'b0, 1'b0);
        // Accumulate, carry at bit 32 and borrow below zero
        addEntry(3'b011, 32'h00000001, 32'h00000001, 64'h00000001_ffffffff, 1'b0, 1'b0);
        addEntry(3'b010, 32'h00000002, 32'h00000003, 64'd0, 1'b0, 1'b0);
        addEntry(3'b111, 32'hffffffff, 32'hffffffff, 64'hffffffff_ffffffff, 1'b0, 1'b0);
        addEntry(3'b110, 32'hfffffffe, 32'h00000003, 64'd5, 1'b0, 1'b0);
        // Cancel then recovery
        addEntry(3'b000, 32'hdeadbeef, 32'h00001234, 64'd0, 1'b1, 1'b0);
        addEntry(3'b011, 32'h00010000, 32'h00010000, 64'h00000000_ffffffff, 1'b0, 1'b0);
        // Back-to-back, same hiLo
        addEntry(3'b010, 32'h00001000, 32'h00000010, 64'h00000000_ffffffff, 1'b0, 1'b1);
        addEntry(3'b100, 32'h80000001, 32'h00000002, 64'h00000000_ffffffff, 1'b0, 1'b1);
        while (nEntries < NUM_ENTRIES) begin
            randBits(3, mode);
            randBits(32, a);
            randBits(32, b);
            randBits(64, h);
            randBits(4, c);
            randBits(1, bk);
            back = bk[0] && !tCancel[nEntries - 1];
            if (back) begin
                h = tHiLo[nEntries - 1];    // hiLo shared across the overlap
            end
            addEntry(mode[2:0], a[31:0], b[31:0], h, c[3:0] == 4'd0, back);
        end
    endtask

    task automatic applyEntry(input int i);
        @(negedge clk);
        {isSigned, isAccum, addNotSub} = tMode[i];
        opA    = tA[i];
        opB    = tB[i];
        hiLo   = tHiLo[i];
        mulReq = 1'b1;
        do @(posedge clk); while (!opReady);   // Accept edge
        @(negedge clk);
        mulReq = 1'b0;
        if (tCancel[i]) begin
            cancel = 1'b1;
            @(negedge clk);
            cancel = 1'b0;
            repeat (3) @(negedge clk);          // Room for a stray done
        end else if (i + 1 >= nEntries || !tBack[i + 1]) begin
            do @(posedge clk); while (!resultValid);
        end
    endtask

    initial begin
        lfsr      = 32'h476709db;
        rstN      = 1'b0;
        mulReq    = 1'b0;
        cancel    = 1'b0;
        isSigned  = 1'b0;
        isAccum   = 1'b0;
        addNotSub = 1'b0;
        opA       = '0;
        opB       = '0;
        hiLo      = '0;
        buildTable();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        for (int i = 0; i < nEntries; i++) begin
            applyEntry(i);
        end
        repeat (4) @(negedge clk);
        $display("tests %0d passed %0d failed %0d cancelled %0d errors %0d",
                 nEntries, passCount, failCount, cancelCount, errCount);
        if (failCount == 0 && errCount == 0 && cancelCount == nCancels &&
            passCount == nEntries - nCancels) begin
            $display("=== PASS ===");
        end else begin
            if (passCount + failCount + cancelCount != nEntries) begin
                $display("Not every test ended in a result or a cancel");
            end
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
